// ==== design/qspi_pkg.sv ====
// Shared constants and types for the APB to quad-SPI PSRAM controller.
// Modules use scoped names in their port lists and a wildcard import inside.
package qspi_pkg;

  // Bus and shifter widths.
  localparam int ADDR_W = 24;  // Chip byte address.
  localparam int DATA_W = 32;  // APB data word.
  localparam int STRB_W = 4;   // One strobe bit per byte lane.
  localparam int CNT_W  = 6;   // Holds bit counts up to 32.

  // Lengths of the transaction phases.
  localparam int CMD_BITS   = 8;   // Command on one line.
  localparam int ADDR_BITS  = 24;  // Address on four lines.
  localparam int DUMMY_CLKS = 6;   // Read turnaround clocks.
  localparam int READ_BITS  = 32;  // A read always fetches a full word.

  // Command bytes understood by the PSRAM.
  typedef enum logic [7:0] {
    CMD_QUAD_WRITE = 8'h38,
    CMD_QUAD_READ  = 8'hEB
  } cmd_t;

  // Sequencer states, in the order a transaction walks through them.
  typedef enum logic [2:0] {
    IDLE,    // Waiting for a request.
    SELECT,  // Pull chip select low.
    CMD,     // Start the command byte.
    ADDR,    // Start the address.
    DUMMY,   // Start the dummy clocks, reads only.
    DATA,    // Start the data transfer.
    FINISH   // Release the chip and report.
  } state_t;

endpackage

// ==== design/apb_port.sv ====
// APB slave front end of the PSRAM controller.
// Captures one transfer, rejects illegal write strobes with pslverr and holds
// the request until the sequencer reports done.
`timescale 1ns/1ps

module apb_port (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [qspi_pkg::ADDR_W-1:0]  paddr,
  input  logic [qspi_pkg::DATA_W-1:0]  pwdata,
  input  logic [qspi_pkg::STRB_W-1:0]  pstrb,
  output logic                         pready,
  output logic [qspi_pkg::DATA_W-1:0]  prdata,
  output logic                         pslverr,
  output logic                         req_valid,
  output logic                         req_write,
  output logic [qspi_pkg::ADDR_W-1:0]  req_addr,
  output logic [qspi_pkg::DATA_W-1:0]  req_wdata,
  output logic [qspi_pkg::STRB_W-1:0]  req_strb,
  input  logic                         done,
  input  logic [qspi_pkg::DATA_W-1:0]  rd_word
);

  logic strb_ok;
  logic legal;
  logic access;

  // Byte, aligned halfword or full word.
  always_comb begin
    case (pstrb)
      4'b0001, 4'b0010, 4'b0100, 4'b1000,
      4'b0011, 4'b1100, 4'b1111: strb_ok = 1'b1;
      default:                   strb_ok = 1'b0;
    endcase
  end

  assign legal  = !pwrite || strb_ok;  // Reads ignore the strobe.
  assign access = psel && penable && !req_valid && !pready;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      req_valid <= 1'b0;
      pready    <= 1'b0;
      pslverr   <= 1'b0;
    end else begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      if (access && !legal) begin
        pready  <= 1'b1;  // Error response, no chip activity.
        pslverr <= 1'b1;
      end else if (access) begin
        req_valid <= 1'b1;
      end else if (done) begin
        req_valid <= 1'b0;
        pready    <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      req_write <= pwrite;
      req_addr  <= paddr;
      req_wdata <= pwdata;
      req_strb  <= pstrb;
    end
    if (done && !req_write) prdata <= rd_word;
  end

  // The access phase must always follow a setup phase of the same slave.
  a_penable_needs_psel: assert property (@(posedge clk) disable iff (!resetn)
    $rose(penable) |-> psel);

endmodule

// ==== design/write_align.sv ====
// Write strobe decoder for the PSRAM controller.
// Gives the byte offset within the word, the number of data bits to send and
// the write data moved to the top of the shift buffer, first byte in 31:24.
`timescale 1ns/1ps

module write_align (
  input  logic [qspi_pkg::STRB_W-1:0] req_strb,
  input  logic [qspi_pkg::DATA_W-1:0] req_wdata,
  output logic [1:0]                  byte_offset,
  output logic [qspi_pkg::CNT_W-1:0]  wr_bits,
  output logic [qspi_pkg::DATA_W-1:0] wr_buf
);

  import qspi_pkg::*;

  // Lane k sits at chip address word_base + 3 - k.
  always_comb begin
    byte_offset = 2'd0;
    wr_bits     = CNT_W'(DATA_W);
    wr_buf      = req_wdata;
    case (req_strb)
      4'b0001: begin
        byte_offset  = 2'd3;
        wr_bits      = CNT_W'(8);
        wr_buf[31:24] = req_wdata[7:0];
      end
      4'b0010: begin
        byte_offset  = 2'd2;
        wr_bits      = CNT_W'(8);
        wr_buf[31:24] = req_wdata[15:8];
      end
      4'b0100: begin
        byte_offset  = 2'd1;
        wr_bits      = CNT_W'(8);
        wr_buf[31:24] = req_wdata[23:16];
      end
      4'b1000: begin
        wr_bits = CNT_W'(8);  // Already in place.
      end
      4'b0011: begin
        byte_offset  = 2'd2;
        wr_bits      = CNT_W'(16);
        wr_buf[31:16] = req_wdata[15:0];
      end
      4'b1100: wr_bits = CNT_W'(16);  // Upper half already on top.
      default: ;  // Full word.
    endcase
  end

endmodule

// ==== design/sio_shifter.sv ====
// Serial shift engine for the quad-SPI bus.
// A load starts a burst of N bits on one or four lines; sclk runs at half the
// clk rate while bits remain and busy stays high until sclk is back low.
`timescale 1ns/1ps

module sio_shifter (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         load,
  input  logic [qspi_pkg::DATA_W-1:0]  load_data,
  input  logic [qspi_pkg::CNT_W-1:0]   load_bits,
  input  logic                         load_quad,
  input  logic [3:0]                   load_oe,
  output logic                         busy,
  output logic [qspi_pkg::DATA_W-1:0]  shift_data,
  output logic                         sclk,
  output logic [3:0]                   sio_out,
  output logic [3:0]                   sio_oe,
  input  logic [3:0]                   sio_in
);

  import qspi_pkg::*;

  logic [DATA_W-1:0] shreg;
  logic [CNT_W-1:0]  cnt;
  logic              quad;
  logic              rise;
  logic              fall;

  assign rise       = !load && !sclk && (cnt != '0);
  assign fall       = !load && sclk;
  assign busy       = (cnt != '0) || sclk;
  assign shift_data = shreg;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cnt     <= '0;
      quad    <= 1'b0;
      sclk    <= 1'b0;
      sio_oe  <= 4'b0000;
      sio_out <= 4'b0000;
    end else if (load) begin
      cnt     <= load_bits;
      quad    <= load_quad;
      sio_oe  <= load_oe;
      sio_out <= load_quad ? load_data[DATA_W-1 -: 4] : {3'b000, load_data[DATA_W-1]};
    end else if (fall) begin
      sclk    <= 1'b0;
      sio_out <= quad ? shreg[DATA_W-1 -: 4] : {3'b000, shreg[DATA_W-1]};  // Next bits.
    end else if (rise) begin
      sclk <= 1'b1;
      cnt  <= quad ? cnt - CNT_W'(4) : cnt - CNT_W'(1);
    end
  end

  // Input sampled as sclk goes high.
  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= load_data;
    end else if (rise) begin
      shreg <= quad ? {shreg[DATA_W-5:0], sio_in} : {shreg[DATA_W-2:0], sio_in[1]};
    end
  end

  // The sequencer must wait for the previous burst to end.
  a_no_load_while_busy: assert property (@(posedge clk) disable iff (!resetn)
    load |-> !busy);

endmodule

// ==== design/qspi_ctrl.sv ====
// Transaction sequencer for the quad-SPI PSRAM.
// Turns one request into select, command, address, optional dummy and data
// phases on the shifter, then releases the chip and pulses done.
`timescale 1ns/1ps

module qspi_ctrl (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         req_valid,
  input  logic                         req_write,
  input  logic [qspi_pkg::ADDR_W-1:0]  req_addr,
  input  logic [1:0]                   byte_offset,
  input  logic [qspi_pkg::CNT_W-1:0]   wr_bits,
  input  logic [qspi_pkg::DATA_W-1:0]  wr_buf,
  output logic                         load,
  output logic [qspi_pkg::DATA_W-1:0]  load_data,
  output logic [qspi_pkg::CNT_W-1:0]   load_bits,
  output logic                         load_quad,
  output logic [3:0]                   load_oe,
  input  logic                         busy,
  input  logic [qspi_pkg::DATA_W-1:0]  shift_data,
  output logic                         cs_n,
  output logic                         done,
  output logic [qspi_pkg::DATA_W-1:0]  rd_word
);

  import qspi_pkg::*;

  state_t            state;
  state_t            state_d;
  cmd_t              cmd;
  logic [ADDR_W-1:0] addr;

  assign cmd     = req_write ? CMD_QUAD_WRITE : CMD_QUAD_READ;
  assign addr    = {req_addr[ADDR_W-1:2], req_write ? byte_offset : 2'b00};  // Reads fetch whole word.
  assign rd_word = shift_data;

  // Each phase loads the shifter once busy has dropped.
  always_comb begin
    state_d   = state;
    load      = 1'b0;
    load_data = '0;
    load_bits = '0;
    load_quad = 1'b0;
    load_oe   = 4'b0000;
    done      = 1'b0;
    case (state)
      IDLE: begin
        if (req_valid) state_d = SELECT;
      end
      SELECT: state_d = CMD;
      CMD: begin
        load      = 1'b1;
        load_data = {cmd, {(DATA_W - CMD_BITS){1'b0}}};
        load_bits = CNT_W'(CMD_BITS);
        load_oe   = 4'b0001;  // Command goes out on sio0 only.
        state_d   = ADDR;
      end
      ADDR: begin
        if (!busy) begin
          load      = 1'b1;
          load_data = {addr, {(DATA_W - ADDR_BITS){1'b0}}};
          load_bits = CNT_W'(ADDR_BITS);
          load_quad = 1'b1;
          load_oe   = 4'b1111;
          state_d   = req_write ? DATA : DUMMY;
        end
      end
      DUMMY: begin
        if (!busy) begin
          load      = 1'b1;
          load_bits = CNT_W'(DUMMY_CLKS);  // Lines released for turnaround.
          state_d   = DATA;
        end
      end
      DATA: begin
        if (!busy) begin
          load      = 1'b1;
          load_quad = 1'b1;
          if (req_write) begin
            load_data = wr_buf;
            load_bits = wr_bits;
            load_oe   = 4'b1111;
          end else begin
            load_bits = CNT_W'(READ_BITS);
          end
          state_d = FINISH;
        end
      end
      FINISH: begin
        if (!busy) begin
          done    = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= IDLE;
      cs_n  <= 1'b1;
    end else begin
      state <= state_d;
      if (state == SELECT) begin
        cs_n <= 1'b0;
      end else if (done) begin
        cs_n <= 1'b1;  // Last sclk already back low.
      end
    end
  end

  // The serial clock may only run while the chip is selected.
  a_no_sclk_deselected: assert property (@(posedge clk) disable iff (!resetn)
    cs_n |-> !busy);

endmodule

// ==== design/qspi_psram_top.sv ====
// Top level of the APB to quad-SPI PSRAM controller.
// Data pins are split into out, enable and in; the pad buffer sits outside.
`timescale 1ns/1ps

module qspi_psram_top (
  input  logic                         clk,
  input  logic                         resetn,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [qspi_pkg::ADDR_W-1:0]  paddr,
  input  logic [qspi_pkg::DATA_W-1:0]  pwdata,
  input  logic [qspi_pkg::STRB_W-1:0]  pstrb,
  output logic                         pready,
  output logic [qspi_pkg::DATA_W-1:0]  prdata,
  output logic                         pslverr,
  output logic                         cs_n,
  output logic                         sclk,
  output logic [3:0]                   sio_out,
  output logic [3:0]                   sio_oe,
  input  logic [3:0]                   sio_in
);

  import qspi_pkg::*;

  logic              req_valid;
  logic              req_write;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_wdata;
  logic [STRB_W-1:0] req_strb;
  logic              done;
  logic [DATA_W-1:0] rd_word;
  logic [1:0]        byte_offset;
  logic [CNT_W-1:0]  wr_bits;
  logic [DATA_W-1:0] wr_buf;
  logic              load;
  logic [DATA_W-1:0] load_data;
  logic [CNT_W-1:0]  load_bits;
  logic              load_quad;
  logic [3:0]        load_oe;
  logic              busy;
  logic [DATA_W-1:0] shift_data;

  apb_port u_apb_port (
    .clk       (clk),
    .resetn    (resetn),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .pready    (pready),
    .prdata    (prdata),
    .pslverr   (pslverr),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_strb  (req_strb),
    .done      (done),
    .rd_word   (rd_word)
  );

  write_align u_write_align (
    .req_strb    (req_strb),
    .req_wdata   (req_wdata),
    .byte_offset (byte_offset),
    .wr_bits     (wr_bits),
    .wr_buf      (wr_buf)
  );

  sio_shifter u_sio_shifter (
    .clk        (clk),
    .resetn     (resetn),
    .load       (load),
    .load_data  (load_data),
    .load_bits  (load_bits),
    .load_quad  (load_quad),
    .load_oe    (load_oe),
    .busy       (busy),
    .shift_data (shift_data),
    .sclk       (sclk),
    .sio_out    (sio_out),
    .sio_oe     (sio_oe),
    .sio_in     (sio_in)
  );

  qspi_ctrl u_qspi_ctrl (
    .clk         (clk),
    .resetn      (resetn),
    .req_valid   (req_valid),
    .req_write   (req_write),
    .req_addr    (req_addr),
    .byte_offset (byte_offset),
    .wr_bits     (wr_bits),
    .wr_buf      (wr_buf),
    .load        (load),
    .load_data   (load_data),
    .load_bits   (load_bits),
    .load_quad   (load_quad),
    .load_oe     (load_oe),
    .busy        (busy),
    .shift_data  (shift_data),
    .cs_n        (cs_n),
    .done        (done),
    .rd_word     (rd_word)
  );

endmodule

// ==== tb/tb_clock.sv ====
// Clock and synchronous reset source for the testbench.
// Reset is held low for RESET_CYCLES rising edges and released just after an edge.
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 resetn = 1'b1;  // Same small delay as the APB stimulus.
  end

endmodule

// ==== tb/psram_model.sv ====
// Behavioral quad-SPI PSRAM used by the testbench on the chip pins.
// Decodes quad write 38h and quad read EBh, keeps a sparse byte array and
// counts protocol violations on proto_errs.
`timescale 1ns/1ps

module psram_model (
  input  logic       cs_n,
  input  logic       sclk,
  input  logic [3:0] sio_out,
  input  logic [3:0] sio_oe,
  output logic [3:0] sio_in,
  output int         proto_errs
);

  import qspi_pkg::*;

  localparam int ADDR_END   = CMD_BITS + ADDR_BITS / 4;  // First edge after the address.
  localparam int DATA_START = ADDR_END + DUMMY_CLKS;      // First read data edge.

  logic [7:0]  mem [logic [23:0]];
  logic [7:0]  cmd;
  logic [23:0] addr;
  logic [7:0]  wr_byte;
  logic [7:0]  rd_byte;
  int          edges;
  int          sel_count;
  int          sel_seen;
  int          rise_errs;
  int          fall_errs;
  int          wr_n;
  int          rd_n;
  realtime     rise_time;
  realtime     change_time;

  assign proto_errs = rise_errs + fall_errs;

  // Unwritten bytes hold a pattern of the whole address.
  function automatic logic [7:0] fill_byte(input logic [23:0] a);
    return {a[3:0], a[7:4]} ^ a[15:8] ^ a[23:16] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] read_byte(input logic [23:0] a);
    return mem.exists(a) ? mem[a] : fill_byte(a);
  endfunction

  always @(negedge cs_n) sel_count++;      // Marks a new transaction.
  always @(sio_out) change_time = $realtime;

  // Chip samples on the rising edge.
  initial begin
    rise_errs = 0;
    sel_seen  = 0;
    edges     = 0;
    cmd       = '0;
    addr      = '0;
    wr_byte   = '0;
    rise_time = 0.0;
    forever begin
      @(posedge sclk);
      rise_time = $realtime;
      if (sel_seen != sel_count) begin
        sel_seen = sel_count;
        edges    = 0;
      end
      assert (!cs_n) else begin
        $display("psram model: sclk rose while cs_n was high at %0t", $realtime);
        rise_errs++;
      end
      if (edges < CMD_BITS) begin
        assert (sio_oe == 4'b0001) else begin
          $display("psram model: command sent with sio_oe %b at %0t", sio_oe, $realtime);
          rise_errs++;
        end
        cmd = {cmd[6:0], sio_out[0]};  // MSB first on sio0.
      end else if (edges < ADDR_END) begin
        addr = {addr[19:0], sio_out};
      end else if (cmd == CMD_QUAD_WRITE) begin
        wr_n = edges - ADDR_END;
        if (wr_n % 2 == 0) begin
          wr_byte[7:4] = sio_out;
        end else begin
          wr_byte[3:0] = sio_out;
          mem[addr + 24'(wr_n / 2)] = wr_byte;
        end
      end else if (edges >= DATA_START) begin
        assert (sio_oe == 4'b0000) else begin
          $display("psram model: controller drives sio during read data at %0t", $realtime);
          rise_errs++;
        end
      end
      if (edges == CMD_BITS - 1) begin
        assert (cmd == CMD_QUAD_WRITE || cmd == CMD_QUAD_READ) else begin
          $display("psram model: unknown command %h at %0t", cmd, $realtime);
          rise_errs++;
        end
      end
      edges++;
    end
  end

  // Read data goes out on the falling edge.
  initial begin
    fall_errs = 0;
    sio_in    = 4'h0;
    forever begin
      @(negedge sclk);
      assert (!(change_time > rise_time && change_time < $realtime)) else begin
        $display("psram model: data lines changed while sclk was high at %0t", change_time);
        fall_errs++;
      end
      if (!cs_n && cmd == CMD_QUAD_READ && edges >= DATA_START) begin
        rd_n    = edges - DATA_START;
        rd_byte = read_byte(addr + 24'(rd_n / 2));
        sio_in  = rd_n[0] ? rd_byte[3:0] : rd_byte[7:4];
      end
    end
  end

endmodule

// ==== tb/tb_top.sv ====
// Testbench for the APB to quad-SPI PSRAM controller.
// Drives APB transfers from an LFSR, predicts read data with a byte-array
// reference memory and reports one line per test plus a closing count.
`timescale 1ns/1ps

module tb_top;

  import qspi_pkg::*;

  localparam int CLK_NS       = 40;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DLY    = 1;
  localparam int XFER_LIMIT   = 150;  // Clocks to wait for pready.
  localparam int FULL_N       = 8;
  localparam int BYTE_N       = 8;
  localparam int HALF_N       = 4;
  localparam int BAD_N        = 4;
  localparam int MIX_N        = 60;
  localparam int NUM_XFERS    = 2 * (FULL_N + BYTE_N + HALF_N + BAD_N) + MIX_N;
  localparam int XFER_CLKS    = 120;
  localparam int WDOG_MARGIN  = 500;

  logic              clk;
  logic              resetn;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [DATA_W-1:0] pwdata;
  logic [STRB_W-1:0] pstrb;
  logic              pready;
  logic [DATA_W-1:0] prdata;
  logic              pslverr;
  logic              cs_n;
  logic              sclk;
  logic [3:0]        sio_out;
  logic [3:0]        sio_oe;
  logic [3:0]        sio_in;
  int                proto_errs;

  logic [31:0] lfsr = 32'h8f6aa998;
  logic [7:0]  ref_mem [logic [23:0]];
  logic [3:0]  good_strb [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
  logic [3:0]  bad_strb [BAD_N] = '{4'b0101, 4'b0000, 4'b0111, 4'b1110};
  string       test_name;
  int          errors;
  int          checks;
  int          tests;
  int          test_errs;
  int          test_checks;
  int          cs_falls;

  tb_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .clk    (clk),
    .resetn (resetn)
  );

  qspi_psram_top dut (
    .clk     (clk),
    .resetn  (resetn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .pready  (pready),
    .prdata  (prdata),
    .pslverr (pslverr),
    .cs_n    (cs_n),
    .sclk    (sclk),
    .sio_out (sio_out),
    .sio_oe  (sio_oe),
    .sio_in  (sio_in)
  );

  psram_model u_psram (
    .cs_n       (cs_n),
    .sclk       (sclk),
    .sio_out    (sio_out),
    .sio_oe     (sio_oe),
    .sio_in     (sio_in),
    .proto_errs (proto_errs)
  );

  always @(negedge cs_n) cs_falls++;  // Chip transactions started.

  // Galois LFSR stepped once per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD0000001) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [23:0] rand_addr();
    logic [31:0] r;
    r = rand_bits(22);
    return {r[21:0], 2'b00};
  endfunction

  // Same address-wide pattern the PSRAM powers up with in this bench.
  function automatic logic [7:0] fill_byte(input logic [23:0] a);
    return {a[3:0], a[7:4]} ^ a[15:8] ^ a[23:16] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] ref_byte(input logic [23:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
  endfunction

  // Lane k lives at word_base + 3 - k, so the lowest address is bits 31:24.
  function automatic logic [31:0] ref_word(input logic [23:0] base);
    return {ref_byte(base), ref_byte(base + 24'd1), ref_byte(base + 24'd2),
            ref_byte(base + 24'd3)};
  endfunction

  function automatic logic strobe_legal(input logic [3:0] s);
    return s inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111};
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  // Setup phase, access phase, then wait for pready.
  task automatic apb_transfer(input logic wr, input logic [23:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic err);
    int waited;
    waited  = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = strb;
    @(posedge clk);
    #DRIVE_DLY;
    penable = 1'b1;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end while (!pready && waited < XFER_LIMIT);
    rdata = prdata;
    err   = pslverr;
    checks++;
    assert (pready) else begin
      $display("%s: no pready within %0d clocks for address %h", test_name, XFER_LIMIT, addr);
      errors++;
    end
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_word(input logic [23:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    logic [31:0] rd;
    logic        err;
    logic        legal;
    int          falls;
    legal = strobe_legal(strb);
    falls = cs_falls;
    apb_transfer(1'b1, addr, data, strb, rd, err);
    check_value($sformatf("pslverr strb %b", strb), {31'd0, !legal}, {31'd0, err});
    if (legal) begin
      for (int k = 0; k < 4; k++) begin
        if (strb[k]) ref_mem[addr + 24'(3 - k)] = data[8*k +: 8];
      end
    end else begin
      check_value("chip selects on rejected write", 32'(falls), 32'(cs_falls));
    end
  endtask

  task automatic read_check(input logic [23:0] addr);
    logic [31:0] rd;
    logic [31:0] r;
    logic        err;
    r = rand_bits(4);
    apb_transfer(1'b0, addr, 32'h0, r[3:0], rd, err);  // Any strobe, reads ignore it.
    check_value("read pslverr", 32'd0, {31'd0, err});
    check_value($sformatf("read %h", addr), ref_word(addr), rd);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errs   = errors;
    test_checks = checks;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s finished: %0d checks, %0d errors", test_name,
             checks - test_checks, errors - test_errs);
  endtask

  initial begin
    #(CLK_NS * (NUM_XFERS * XFER_CLKS + WDOG_MARGIN));
    $display("Watchdog expired before the %0d transfers completed", NUM_XFERS);
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [23:0] a;
    logic [23:0] base;
    logic [31:0] r;
    logic [3:0]  s;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
    @(posedge resetn);
    @(posedge clk);
    #DRIVE_DLY;

    start_test("reset_state");
    repeat (8) begin
      check_value("idle cs_n,sclk,sio_oe,pready,pslverr", 32'h80,
                  {24'd0, cs_n, sclk, sio_oe, pready, pslverr});
      @(posedge clk);
      #DRIVE_DLY;
    end
    end_test();

    start_test("full_word");
    repeat (FULL_N) begin
      a = rand_addr();
      write_word(a, rand_bits(32), 4'b1111);
      read_check(a);
    end
    end_test();

    start_test("single_byte");
    for (int i = 0; i < BYTE_N; i++) begin
      a = rand_addr();
      write_word(a, rand_bits(32), 4'(1 << (i % 4)));
      read_check(a);
    end
    end_test();

    start_test("halfword");
    for (int i = 0; i < HALF_N; i++) begin
      a = rand_addr();
      write_word(a, rand_bits(32), (i % 2 == 1) ? 4'b1100 : 4'b0011);
      read_check(a);
    end
    end_test();

    start_test("illegal_strobe");
    for (int i = 0; i < BAD_N; i++) begin
      a = rand_addr();
      write_word(a, rand_bits(32), bad_strb[i]);
      read_check(a);  // Word must be untouched.
    end
    end_test();

    start_test("mixed_random");
    base = rand_addr();
    repeat (MIX_N) begin
      r = rand_bits(3);
      a = base + 24'({r[2:0], 2'b00});  // Small pool so reads hit writes.
      r = rand_bits(1);
      if (r[0]) begin
        read_check(a);
      end else begin
        r = rand_bits(3);
        if (r[2:0] == 3'd7) begin
          r = rand_bits(4);
          s = r[3:0];  // Any strobe, legal or not.
        end else begin
          s = good_strb[r[2:0]];
        end
        write_word(a, rand_bits(32), s);
      end
      r = rand_bits(4);
      repeat (r[3:0]) begin
        @(posedge clk);
        #DRIVE_DLY;
      end
    end
    check_value("model protocol errors", 32'd0, 32'(proto_errs));
    end_test();

    $display("tests %0d, checks %0d, errors %0d, protocol errors %0d",
             tests, checks, errors, proto_errs);
    if (errors == 0 && proto_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
design/qspi_pkg.sv
design/apb_port.sv
design/write_align.sv
design/sio_shifter.sv
design/qspi_ctrl.sv
design/qspi_psram_top.sv
tb/tb_clock.sv
tb/psram_model.sv
tb/tb_top.sv

// ==== Makefile ====
# Verilator flow for the APB quad-SPI PSRAM controller.
# make builds and runs the testbench, make lint checks the RTL, make clean tidies up.

OBJ := obj_dir

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module tb_top -Mdir $(OBJ) -f compile.f
	./$(OBJ)/Vtb_top | tee /dev/stderr | grep -x 'No errors' > /dev/null

lint:
	verilator --lint-only -Wall --top-module qspi_psram_top \
	  design/qspi_pkg.sv design/apb_port.sv design/write_align.sv \
	  design/sio_shifter.sv design/qspi_ctrl.sv design/qspi_psram_top.sv

clean:
	rm -rf $(OBJ)
